//--- hw/be_macros.svh
`ifndef BE_MACROS_SVH
`define BE_MACROS_SVH

// Datapath widths
`define BE_VADDR_WIDTH      39
`define BE_REG_DATA_WIDTH   64
`define BE_ITAG_WIDTH       8
`define BE_BMETA_WIDTH      16
`define BE_INSTR_WIDTH      32
`define BE_REG_ADDR_WIDTH   5
`define BE_OPCODE_WIDTH     7
`define BE_EXC_CODE_WIDTH   4

// Exception layout is padded up to the fetch layout width
// so both fit the same message bits
`define BE_FE_EXC_PAD_WIDTH (`BE_INSTR_WIDTH + `BE_BMETA_WIDTH - `BE_EXC_CODE_WIDTH)

// Reset PC, word aligned
`define BE_BOOT_PC          39'h00_8000_0000

// Front-end queue sizing
`define BE_FEQ_DEPTH_LOG2   2
`define BE_FEQ_DEPTH        (1 << `BE_FEQ_DEPTH_LOG2)

// RV64 major opcodes
`define RV64_LUI_OP         7'b0110111
`define RV64_AUIPC_OP       7'b0010111
`define RV64_JAL_OP         7'b1101111
`define RV64_JALR_OP        7'b1100111
`define RV64_BRANCH_OP      7'b1100011
`define RV64_LOAD_OP        7'b0000011
`define RV64_STORE_OP       7'b0100011
`define RV64_OP_IMM_OP      7'b0010011
`define RV64_OP_IMM_32_OP   7'b0011011
`define RV64_OP_OP          7'b0110011
`define RV64_OP_32_OP       7'b0111011

// Front-end exception codes
`define BE_EXC_INSTR_MISALIGNED    4'd0
`define BE_EXC_INSTR_ACCESS_FAULT  4'd1

`endif

//--- hw/fe_be_if_pkg.sv
`include "be_macros.svh"

package fe_be_if_pkg;

   // Sv39 virtual address
   typedef logic [`BE_VADDR_WIDTH-1:0] vaddr_t;

   // Opaque branch predictor state, carried through
   typedef logic [`BE_BMETA_WIDTH-1:0] bmeta_t;

   typedef logic [`BE_EXC_CODE_WIDTH-1:0] exc_code_t;

   // Queue pointer, one bit wider than the index
   typedef logic [`BE_FEQ_DEPTH_LOG2:0] feq_ptr_t;

   typedef enum logic
   {
      e_fe_fetch     = 1'b0,
      e_fe_exception = 1'b1
   } fe_msg_type_e;

   // Fetched instruction with its PC
   typedef struct packed
   {
      vaddr_t                      pc;
      logic [`BE_INSTR_WIDTH-1:0]  instr;
      bmeta_t                      branch_metadata_fwd;
   } fe_fetch_s;

   // Faulting address and cause
   typedef struct packed
   {
      vaddr_t                           vaddr;
      exc_code_t                        exception_code;
      logic [`BE_FE_EXC_PAD_WIDTH-1:0]  padding;
   } fe_exception_s;

   // Both layouts share the message bits
   typedef union packed
   {
      fe_fetch_s      fetch;
      fe_exception_s  exception;
   } fe_msg_u;

   typedef struct packed
   {
      fe_msg_type_e  msg_type;
      fe_msg_u       msg;
   } fe_queue_s;

endpackage

//--- hw/be_issue_pkg.sv
`include "be_macros.svh"

package be_issue_pkg;

   import fe_be_if_pkg::*;

   // Issue order tag
   typedef logic [`BE_ITAG_WIDTH-1:0] itag_t;

   typedef logic [`BE_REG_DATA_WIDTH-1:0] reg_data_t;

   // Architectural register index
   typedef logic [`BE_REG_ADDR_WIDTH-1:0] reg_addr_t;

   typedef logic [`BE_OPCODE_WIDTH-1:0] opcode_t;

   // RV base encoding, MSB first
   typedef struct packed
   {
      logic [6:0]  funct7;
      reg_addr_t   rs2_addr;
      reg_addr_t   rs1_addr;
      logic [2:0]  funct3;
      reg_addr_t   rd_addr;
      opcode_t     opcode;
   } instr_t;

   // Per-instruction bookkeeping for the calculator
   typedef struct packed
   {
      itag_t      itag;
      reg_data_t  pc;
      logic       fe_exception_not_instr;
      exc_code_t  fe_exception_code;
      bmeta_t     branch_metadata_fwd;
   } instr_metadata_s;

   typedef struct packed
   {
      instr_metadata_s  instr_metadata;
      instr_t           instr;
      logic             irs1_v;
      logic             irs2_v;
      logic             frs1_v;
      logic             frs2_v;
      reg_addr_t        rs1_addr;
      reg_addr_t        rs2_addr;
      reg_data_t        imm;
   } issue_pkt_s;

endpackage

//--- hw/fe_fetch_gen.sv
`timescale 1ns/10ps

`include "be_macros.svh"

module fe_fetch_gen
   import fe_be_if_pkg::*;
   import be_issue_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   // Fetch side
   input  logic       fetch_v_i,
   input  instr_t     fetch_instr_i,
   input  logic       fetch_fault_i,
   input  bmeta_t     fetch_bmeta_i,

   // PC redirect
   input  logic       redirect_v_i,
   input  vaddr_t     redirect_pc_i,

   // Queue write port
   input  logic       feq_ready_i,
   output logic       feq_v_o,
   output fe_queue_s  feq_msg_o
);

   vaddr_t pc_r;
   vaddr_t pc_n;
   logic   redirect_misaligned;
   logic   redirect_fire;
   logic   fetch_sel;
   logic   fetch_fire;

   // Target must be word aligned
   assign redirect_misaligned = |redirect_pc_i[1:0];

   // Redirect wins over a fetch in the same cycle
   assign fetch_sel     = fetch_v_i & ~redirect_v_i;
   assign redirect_fire = redirect_v_i & feq_ready_i;
   assign fetch_fire    = fetch_sel & feq_ready_i;

   // Aligned redirects only move the PC
   assign feq_v_o = (redirect_v_i & redirect_misaligned) | fetch_sel;

   always_comb
   begin
      feq_msg_o = '0;
      if (redirect_v_i)
      begin
         feq_msg_o.msg_type                     = e_fe_exception;
         feq_msg_o.msg.exception.vaddr          = redirect_pc_i;
         feq_msg_o.msg.exception.exception_code = `BE_EXC_INSTR_MISALIGNED;
      end
      else if (fetch_fault_i)
      begin
         // Faulting fetch reports its own PC
         feq_msg_o.msg_type                     = e_fe_exception;
         feq_msg_o.msg.exception.vaddr          = pc_r;
         feq_msg_o.msg.exception.exception_code = `BE_EXC_INSTR_ACCESS_FAULT;
      end
      else
      begin
         feq_msg_o.msg_type                      = e_fe_fetch;
         feq_msg_o.msg.fetch.pc                  = pc_r;
         feq_msg_o.msg.fetch.instr               = fetch_instr_i;
         feq_msg_o.msg.fetch.branch_metadata_fwd = fetch_bmeta_i;
      end
   end

   // Next PC, only on accepted inputs
   always_comb
   begin
      pc_n = pc_r;
      if (redirect_fire & ~redirect_misaligned)
         pc_n = redirect_pc_i;
      else if (fetch_fire & ~fetch_fault_i)
         pc_n = pc_r + vaddr_t'(4);
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         pc_r <= `BE_BOOT_PC;
      else
         pc_r <= pc_n;
   end

endmodule

//--- hw/fe_queue_fifo.sv
`timescale 1ns/10ps

`include "be_macros.svh"

module fe_queue_fifo
   import fe_be_if_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   // Write side
   input  logic       wr_v_i,
   input  fe_queue_s  wr_msg_i,
   output logic       wr_ready_o,

   // Read side, oldest entry
   output logic       rd_v_o,
   output fe_queue_s  rd_msg_o,
   input  logic       rd_pop_i
);

   fe_queue_s mem [`BE_FEQ_DEPTH];

   feq_ptr_t wr_ptr_r;
   feq_ptr_t rd_ptr_r;
   logic     full;
   logic     empty;
   logic     wr_fire;
   logic     rd_fire;

   // Same index, wrap bits differ when full
   assign empty = (wr_ptr_r == rd_ptr_r);
   assign full  = (wr_ptr_r[`BE_FEQ_DEPTH_LOG2] != rd_ptr_r[`BE_FEQ_DEPTH_LOG2]) &&
                  (wr_ptr_r[`BE_FEQ_DEPTH_LOG2-1:0] == rd_ptr_r[`BE_FEQ_DEPTH_LOG2-1:0]);

   // Ready from current occupancy only, a pop frees space next cycle
   assign wr_ready_o = ~full;
   assign rd_v_o     = ~empty;

   assign wr_fire = wr_v_i & ~full;
   assign rd_fire = rd_pop_i & ~empty;

   // Registered storage, no write-to-read bypass
   assign rd_msg_o = mem[rd_ptr_r[`BE_FEQ_DEPTH_LOG2-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (wr_fire)
         mem[wr_ptr_r[`BE_FEQ_DEPTH_LOG2-1:0]] <= wr_msg_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
      end
      else
      begin
         if (wr_fire)
            wr_ptr_r <= wr_ptr_r + feq_ptr_t'(1);
         if (rd_fire)
            rd_ptr_r <= rd_ptr_r + feq_ptr_t'(1);
      end
   end

endmodule

//--- hw/be_scheduler.sv
`timescale 1ns/10ps

`include "be_macros.svh"

module be_scheduler
   import fe_be_if_pkg::*;
   import be_issue_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,

   // Front-end queue head
   input  logic        feq_v_i,
   input  fe_queue_s   feq_msg_i,
   output logic        feq_pop_o,

   // Issue to calculator
   input  logic        issue_ready_i,
   output logic        issue_v_o,
   output issue_pkt_s  issue_pkt_o
);

   // U type, upper 20 bits
   function automatic reg_data_t imm_u(input logic [`BE_INSTR_WIDTH-1:0] i);
      return {{32{i[31]}}, i[31:12], 12'b0};
   endfunction

   // J type, scrambled 20-bit offset
   function automatic reg_data_t imm_j(input logic [`BE_INSTR_WIDTH-1:0] i);
      return {{44{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
   endfunction

   // B type, 12-bit branch offset
   function automatic reg_data_t imm_b(input logic [`BE_INSTR_WIDTH-1:0] i);
      return {{52{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
   endfunction

   // S type, split store offset
   function automatic reg_data_t imm_s(input logic [`BE_INSTR_WIDTH-1:0] i);
      return {{53{i[31]}}, i[30:25], i[11:7]};
   endfunction

   function automatic reg_data_t imm_i(input logic [`BE_INSTR_WIDTH-1:0] i);
      return {{53{i[31]}}, i[30:20]};
   endfunction

   fe_fetch_s     fe_fetch;
   fe_exception_s fe_exception;
   instr_t        fetch_instr;
   itag_t         itag_r;

   assign fe_fetch     = feq_msg_i.msg.fetch;
   assign fe_exception = feq_msg_i.msg.exception;
   assign fetch_instr  = fe_fetch.instr;

   // Ready-then-valid, issue and pop move together
   assign issue_v_o = feq_v_i & issue_ready_i;
   assign feq_pop_o = feq_v_i & issue_ready_i;

   // New tag per issued packet, wraps
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         itag_r <= '0;
      else if (issue_v_o)
         itag_r <= itag_r + itag_t'(1);
   end

   always_comb
   begin
      issue_pkt_o = '0;
      issue_pkt_o.instr_metadata.itag = itag_r;
      if (feq_msg_i.msg_type == e_fe_fetch)
      begin
         // Fetch PC zero extended into the register width
         issue_pkt_o.instr_metadata.pc                  = reg_data_t'(fe_fetch.pc);
         issue_pkt_o.instr_metadata.branch_metadata_fwd = fe_fetch.branch_metadata_fwd;
         issue_pkt_o.instr                              = fetch_instr;

         // Integer regfile reads by opcode class
         case (fetch_instr.opcode)
            `RV64_LUI_OP, `RV64_AUIPC_OP, `RV64_JAL_OP:
            begin
               issue_pkt_o.irs1_v = 1'b0;
               issue_pkt_o.irs2_v = 1'b0;
            end
            `RV64_JALR_OP, `RV64_LOAD_OP, `RV64_OP_IMM_OP, `RV64_OP_IMM_32_OP:
            begin
               issue_pkt_o.irs1_v = 1'b1;
               issue_pkt_o.irs2_v = 1'b0;
            end
            `RV64_BRANCH_OP, `RV64_STORE_OP, `RV64_OP_OP, `RV64_OP_32_OP:
            begin
               issue_pkt_o.irs1_v = 1'b1;
               issue_pkt_o.irs2_v = 1'b1;
            end
            default:
            begin
               issue_pkt_o.irs1_v = 1'b0;
               issue_pkt_o.irs2_v = 1'b0;
            end
         endcase

         // No FP predecode, FP flags stay zero
         issue_pkt_o.frs1_v = 1'b0;
         issue_pkt_o.frs2_v = 1'b0;

         // Fixed source field positions
         issue_pkt_o.rs1_addr = fetch_instr.rs1_addr;
         issue_pkt_o.rs2_addr = fetch_instr.rs2_addr;

         // Immediate by format
         case (fetch_instr.opcode)
            `RV64_LUI_OP, `RV64_AUIPC_OP:
               issue_pkt_o.imm = imm_u(fetch_instr);
            `RV64_JAL_OP:
               issue_pkt_o.imm = imm_j(fetch_instr);
            `RV64_BRANCH_OP:
               issue_pkt_o.imm = imm_b(fetch_instr);
            `RV64_STORE_OP:
               issue_pkt_o.imm = imm_s(fetch_instr);
            `RV64_JALR_OP, `RV64_LOAD_OP, `RV64_OP_IMM_OP, `RV64_OP_IMM_32_OP:
               issue_pkt_o.imm = imm_i(fetch_instr);
            default:
               issue_pkt_o.imm = '0;
         endcase
      end
      else
      begin
         // Exception carries only address, code and flag
         issue_pkt_o.instr_metadata.pc                     =
            reg_data_t'($signed(fe_exception.vaddr));
         issue_pkt_o.instr_metadata.fe_exception_not_instr = 1'b1;
         issue_pkt_o.instr_metadata.fe_exception_code      = fe_exception.exception_code;
      end
   end

endmodule

//--- hw/be_frontend_top.sv
`timescale 1ns/10ps

module be_frontend_top
   import fe_be_if_pkg::*;
   import be_issue_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,

   // Fetch and redirect, one shared ready
   input  logic        fetch_v_i,
   input  instr_t      fetch_instr_i,
   input  logic        fetch_fault_i,
   input  bmeta_t      fetch_bmeta_i,
   input  logic        redirect_v_i,
   input  vaddr_t      redirect_pc_i,
   output logic        fetch_ready_o,

   // Issue port
   input  logic        issue_ready_i,
   output logic        issue_v_o,
   output issue_pkt_s  issue_pkt_o
);

   // Producer to queue
   logic      feq_wr_v;
   fe_queue_s feq_wr_msg;
   logic      feq_wr_ready;

   // Queue to scheduler
   logic      feq_rd_v;
   fe_queue_s feq_rd_msg;
   logic      feq_pop;

   assign fetch_ready_o = feq_wr_ready;

   fe_fetch_gen u_fetch_gen
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .fetch_v_i     (fetch_v_i),
      .fetch_instr_i (fetch_instr_i),
      .fetch_fault_i (fetch_fault_i),
      .fetch_bmeta_i (fetch_bmeta_i),
      .redirect_v_i  (redirect_v_i),
      .redirect_pc_i (redirect_pc_i),
      .feq_ready_i   (feq_wr_ready),
      .feq_v_o       (feq_wr_v),
      .feq_msg_o     (feq_wr_msg)
   );

   fe_queue_fifo u_feq
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_v_i     (feq_wr_v),
      .wr_msg_i   (feq_wr_msg),
      .wr_ready_o (feq_wr_ready),
      .rd_v_o     (feq_rd_v),
      .rd_msg_o   (feq_rd_msg),
      .rd_pop_i   (feq_pop)
   );

   be_scheduler u_scheduler
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .feq_v_i       (feq_rd_v),
      .feq_msg_i     (feq_rd_msg),
      .feq_pop_o     (feq_pop),
      .issue_ready_i (issue_ready_i),
      .issue_v_o     (issue_v_o),
      .issue_pkt_o   (issue_pkt_o)
   );

endmodule

//--- testbench/tb_be_frontend.sv
`timescale 1ns/10ps

`include "be_macros.svh"

module tb_be_frontend
   import fe_be_if_pkg::*;
   import be_issue_pkg::*;
();

   localparam int CLK_PERIOD      = 100;
   localparam int RESET_CYCLES    = 10;
   localparam int DIRECTED_CYCLES = 20;
   localparam int BP_CYCLES       = 8;
   localparam int RANDOM_CYCLES   = 1200;
   localparam int DRAIN_LIMIT     = 20;
   // Three drain phases, each bounded
   localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + BP_CYCLES
                                    + RANDOM_CYCLES + 3 * DRAIN_LIMIT;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       fetch_v;
   instr_t     fetch_instr;
   logic       fetch_fault;
   bmeta_t     fetch_bmeta;
   logic       redirect_v;
   vaddr_t     redirect_pc;
   logic       fetch_ready;
   logic       issue_ready;
   logic       issue_v;
   issue_pkt_s issue_pkt;

   // Reference model state
   issue_pkt_s  exp_q [$];
   issue_pkt_s  exp_head;
   int          exp_count;
   vaddr_t      model_pc;
   itag_t       push_itag;
   int          issued;
   int          mismatch_errs = 0;
   int          other_errs    = 0;
   logic [31:0] rng;

   always #(CLK_PERIOD / 2) clk = ~clk;

   be_frontend_top u_dut
   (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .fetch_v_i     (fetch_v),
      .fetch_instr_i (fetch_instr),
      .fetch_fault_i (fetch_fault),
      .fetch_bmeta_i (fetch_bmeta),
      .redirect_v_i  (redirect_v),
      .redirect_pc_i (redirect_pc),
      .fetch_ready_o (fetch_ready),
      .issue_ready_i (issue_ready),
      .issue_v_o     (issue_v),
      .issue_pkt_o   (issue_pkt)
   );

   // Xorshift32 step on the shared state
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Integer reads as {rs1, rs2} per opcode class
   function automatic logic [1:0] expected_reads(input logic [6:0] opcode);
      case (opcode)
         `RV64_JALR_OP, `RV64_LOAD_OP, `RV64_OP_IMM_OP, `RV64_OP_IMM_32_OP:
            return 2'b10;
         `RV64_BRANCH_OP, `RV64_STORE_OP, `RV64_OP_OP, `RV64_OP_32_OP:
            return 2'b11;
         default:
            return 2'b00;
      endcase
   endfunction

   // Offsets rebuilt as signed fields, then widened
   function automatic reg_data_t expected_imm(input instr_t ins);
      logic [31:0]        w;
      logic signed [31:0] u_val;
      logic signed [20:0] j_off;
      logic signed [12:0] b_off;
      logic signed [11:0] s_off;
      logic signed [11:0] i_off;
      w     = ins;
      u_val = {w[31:12], 12'b0};
      j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
      b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
      s_off = {w[31:25], w[11:7]};
      i_off = w[31:20];
      case (ins.opcode)
         `RV64_LUI_OP, `RV64_AUIPC_OP:
            return 64'(u_val);
         `RV64_JAL_OP:
            return 64'(j_off);
         `RV64_BRANCH_OP:
            return 64'(b_off);
         `RV64_STORE_OP:
            return 64'(s_off);
         `RV64_JALR_OP, `RV64_LOAD_OP, `RV64_OP_IMM_OP, `RV64_OP_IMM_32_OP:
            return 64'(i_off);
         default:
            return '0;
      endcase
   endfunction

   function automatic issue_pkt_s fetch_pkt(input itag_t tag, input vaddr_t pc,
                                            input instr_t ins, input bmeta_t bmeta);
      issue_pkt_s p;
      logic [1:0] reads;
      reads = expected_reads(ins.opcode);
      p = '0;
      p.instr_metadata.itag                = tag;
      p.instr_metadata.pc                  = {25'b0, pc};
      p.instr_metadata.branch_metadata_fwd = bmeta;
      p.instr    = ins;
      p.irs1_v   = reads[1];
      p.irs2_v   = reads[0];
      p.rs1_addr = ins.rs1_addr;
      p.rs2_addr = ins.rs2_addr;
      p.imm      = expected_imm(ins);
      return p;
   endfunction

   // Exception packet, address sign extended
   function automatic issue_pkt_s exc_pkt(input itag_t tag, input vaddr_t vaddr,
                                          input exc_code_t code);
      issue_pkt_s p;
      p = '0;
      p.instr_metadata.itag                   = tag;
      p.instr_metadata.pc                     = {{25{vaddr[38]}}, vaddr};
      p.instr_metadata.fe_exception_not_instr = 1'b1;
      p.instr_metadata.fe_exception_code      = code;
      return p;
   endfunction

   function automatic logic [6:0] opcode_at(input int idx);
      case (idx)
         0:       return `RV64_LUI_OP;
         1:       return `RV64_AUIPC_OP;
         2:       return `RV64_JAL_OP;
         3:       return `RV64_JALR_OP;
         4:       return `RV64_BRANCH_OP;
         5:       return `RV64_LOAD_OP;
         6:       return `RV64_STORE_OP;
         7:       return `RV64_OP_IMM_OP;
         8:       return `RV64_OP_IMM_32_OP;
         9:       return `RV64_OP_OP;
         10:      return `RV64_OP_32_OP;
         default: return 7'b1111111;
      endcase
   endfunction

   function automatic instr_t random_instr(input logic [6:0] opcode);
      logic [31:0] r;
      r = next_rand();
      return {r[31:7], opcode};
   endfunction

   // Aligned targets keep bit 38 clear, misaligned ones use all bits
   function automatic vaddr_t random_target(input logic aligned);
      logic [31:0] lo;
      logic [31:0] hi;
      lo = next_rand();
      hi = next_rand();
      if (aligned)
         return {1'b0, hi[5:0], lo[31:2], 2'b00};
      else
         return {hi[6:0], lo[31:2], (lo[1:0] == 2'b00) ? 2'b10 : lo[1:0]};
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                  input logic [63:0] act_val);
      mismatch_errs++;
      $display("MISMATCH at %0t: %s expected %h, actual %h", $time, name, exp_val, act_val);
   endtask

   task automatic report_failure(input string what);
      other_errs++;
      $display("ERROR at %0t: %s", $time, what);
   endtask

   task automatic push_expected(input issue_pkt_s p);
      exp_q.push_back(p);
      push_itag = push_itag + itag_t'(1);
   endtask

   // One cycle of inputs, changed 1 ns after the edge
   task automatic drive(input logic fv, input instr_t ins, input logic fault,
                        input logic rv, input vaddr_t rpc, input logic ir);
      logic [31:0] r;
      r = next_rand();
      fetch_v     = fv;
      fetch_instr = ins;
      fetch_fault = fault;
      fetch_bmeta = r[15:0];
      redirect_v  = rv;
      redirect_pc = rpc;
      issue_ready = ir;
      @(posedge clk);
      #1;
   endtask

   task automatic drain_queue();
      int n;
      n = 0;
      while (exp_count > 0 && n < DRAIN_LIMIT)
      begin
         drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b1);
         n++;
      end
      assert (exp_count == 0)
         else report_failure("queue did not drain with issue ready held high");
   endtask

   // Model follows the producer rules on each accepted input
   always @(posedge clk)
   begin
      logic room;
      if (!rst_n)
      begin
         exp_q.delete();
         exp_head  <= '0;
         exp_count <= 0;
         model_pc  = `BE_BOOT_PC;
         push_itag = '0;
         issued    = 0;
      end
      else
      begin
         // Room is judged on occupancy before this edge's pop
         room = (exp_q.size() < `BE_FEQ_DEPTH);
         if (issue_ready && exp_q.size() > 0)
         begin
            void'(exp_q.pop_front());
            issued++;
         end
         if (room && redirect_v)
         begin
            if (redirect_pc[1:0] != 2'b00)
               push_expected(exc_pkt(push_itag, redirect_pc, `BE_EXC_INSTR_MISALIGNED));
            else
               model_pc = redirect_pc;
         end
         else if (room && fetch_v)
         begin
            if (fetch_fault)
               push_expected(exc_pkt(push_itag, model_pc, `BE_EXC_INSTR_ACCESS_FAULT));
            else
            begin
               push_expected(fetch_pkt(push_itag, model_pc, fetch_instr, fetch_bmeta));
               model_pc = model_pc + vaddr_t'(4);
            end
         end
         if (exp_q.size() > 0)
            exp_head <= exp_q[0];
         exp_count <= exp_q.size();
      end
   end

   // Issued packet against the model head
   itag_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> issue_pkt.instr_metadata.itag == exp_head.instr_metadata.itag)
      else report_mismatch("itag", 64'(exp_head.instr_metadata.itag),
                           64'(issue_pkt.instr_metadata.itag));

   pc_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> issue_pkt.instr_metadata.pc == exp_head.instr_metadata.pc)
      else report_mismatch("pc", exp_head.instr_metadata.pc, issue_pkt.instr_metadata.pc);

   exc_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> {issue_pkt.instr_metadata.fe_exception_not_instr,
                   issue_pkt.instr_metadata.fe_exception_code} ==
                  {exp_head.instr_metadata.fe_exception_not_instr,
                   exp_head.instr_metadata.fe_exception_code})
      else report_mismatch("exception flag and code",
                           64'({exp_head.instr_metadata.fe_exception_not_instr,
                                exp_head.instr_metadata.fe_exception_code}),
                           64'({issue_pkt.instr_metadata.fe_exception_not_instr,
                                issue_pkt.instr_metadata.fe_exception_code}));

   bmeta_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> issue_pkt.instr_metadata.branch_metadata_fwd ==
                  exp_head.instr_metadata.branch_metadata_fwd)
      else report_mismatch("branch_metadata_fwd",
                           64'(exp_head.instr_metadata.branch_metadata_fwd),
                           64'(issue_pkt.instr_metadata.branch_metadata_fwd));

   instr_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> issue_pkt.instr == exp_head.instr)
      else report_mismatch("instr", 64'(exp_head.instr), 64'(issue_pkt.instr));

   // Flags as {irs1, irs2, frs1, frs2}
   flags_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> {issue_pkt.irs1_v, issue_pkt.irs2_v, issue_pkt.frs1_v, issue_pkt.frs2_v} ==
                  {exp_head.irs1_v, exp_head.irs2_v, exp_head.frs1_v, exp_head.frs2_v})
      else report_mismatch("read flags",
                           64'({exp_head.irs1_v, exp_head.irs2_v,
                                exp_head.frs1_v, exp_head.frs2_v}),
                           64'({issue_pkt.irs1_v, issue_pkt.irs2_v,
                                issue_pkt.frs1_v, issue_pkt.frs2_v}));

   addr_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> {issue_pkt.rs1_addr, issue_pkt.rs2_addr} ==
                  {exp_head.rs1_addr, exp_head.rs2_addr})
      else report_mismatch("rs1/rs2 addr", 64'({exp_head.rs1_addr, exp_head.rs2_addr}),
                           64'({issue_pkt.rs1_addr, issue_pkt.rs2_addr}));

   imm_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v |-> issue_pkt.imm == exp_head.imm)
      else report_mismatch("imm", exp_head.imm, issue_pkt.imm);

   // Handshakes against model occupancy
   issue_v_check: assert property (@(negedge clk) disable iff (!rst_n)
      issue_v == (exp_count > 0 && issue_ready))
      else report_mismatch("issue_v_o", 64'(exp_count > 0 && issue_ready), 64'(issue_v));

   ready_check: assert property (@(negedge clk) disable iff (!rst_n)
      fetch_ready == (exp_count < `BE_FEQ_DEPTH))
      else report_mismatch("fetch_ready_o", 64'(exp_count < `BE_FEQ_DEPTH), 64'(fetch_ready));

   hold_check: assert property (@(negedge clk) disable iff (!rst_n)
      !issue_ready |-> !issue_v)
      else report_failure("issue_v_o high while issue ready is low");

   initial
   begin
      int          k;
      logic [31:0] r;
      rng           = 32'h4ac47509;
      rst_n         = 1'b0;
      fetch_v       = 1'b0;
      fetch_instr   = '0;
      fetch_fault   = 1'b0;
      fetch_bmeta   = '0;
      redirect_v    = 1'b0;
      redirect_pc   = '0;
      issue_ready   = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // Empty queue, ready for input
      assert (!issue_v)
         else report_failure("issue_v_o high after reset");
      assert (fetch_ready)
         else report_failure("fetch_ready_o low after reset");

      // Every opcode class and one unknown opcode
      for (k = 0; k < 12; k++)
         drive(1'b1, random_instr(opcode_at(k)), 1'b0, 1'b0, '0, 1'b1);
      // Faulted fetch, PC stays put
      drive(1'b1, random_instr(`RV64_OP_OP), 1'b1, 1'b0, '0, 1'b1);
      // Misaligned target with bit 38 set
      drive(1'b0, '0, 1'b0, 1'b1, 39'h40_1234_5679, 1'b1);
      drive(1'b1, random_instr(`RV64_LOAD_OP), 1'b0, 1'b0, '0, 1'b1);
      drive(1'b0, '0, 1'b0, 1'b1, random_target(1'b1), 1'b1);
      drive(1'b1, random_instr(`RV64_JAL_OP), 1'b0, 1'b0, '0, 1'b1);
      drive(1'b1, random_instr(`RV64_STORE_OP), 1'b0, 1'b0, '0, 1'b1);
      drain_queue();

      // Back-pressure, queue fills at four
      for (k = 0; k < BP_CYCLES; k++)
         drive(1'b1, random_instr(opcode_at(k)), 1'b0, 1'b0, '0, 1'b0);
      assert (!fetch_ready && exp_count == `BE_FEQ_DEPTH)
         else report_failure("fetch_ready_o did not drop after four accepted messages");
      drain_queue();

      // Random mix, long enough to wrap the tag
      for (k = 0; k < RANDOM_CYCLES; k++)
      begin
         r = next_rand();
         drive(r[10:8] != 3'b000, random_instr(opcode_at(int'(r[19:16]) % 12)),
               r[15:12] == 4'h0, r[7:3] == 5'h00, random_target(~r[20]), r[0] | r[1]);
      end
      drain_queue();
      assert (issued > 256)
         else report_failure("too few packets issued to wrap the issue tag");

      $display("Summary: %0d packets issued, %0d mismatch errors, %0d other errors",
               issued, mismatch_errs, other_errs);
      if (mismatch_errs == 0 && other_errs == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Half again the stimulus length
   initial
   begin
      #(TOTAL_CYCLES * 3 / 2 * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, stimulus did not finish",
               TOTAL_CYCLES * 3 / 2);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- tb.f
+incdir+hw
hw/fe_be_if_pkg.sv
hw/be_issue_pkg.sv
hw/fe_fetch_gen.sv
hw/fe_queue_fifo.sv
hw/be_scheduler.sv
hw/be_frontend_top.sv
testbench/tb_be_frontend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_be_frontend
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up on a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
